// File: qpu_exu_pkg.sv
package qpu_exu_pkg;

  //////////////////////////////////////////////////
  // widths
  //////////////////////////////////////////////////

  // classical datapath
  localparam int XLEN      = 32;
  localparam int RIDX_W    = 5;

  // qubit addressing
  localparam int QUBIT_NUM = 8;
  localparam int QIDX_W    = 3;

  // timing and event fields
  localparam int TIME_W    = 16;
  localparam int EVOP_W    = 8;

  // queue flow control, max 15 credits
  localparam int CREDIT_W  = 4;

  //////////////////////////////////////////////////
  // vector types
  //////////////////////////////////////////////////

  typedef logic [XLEN-1:0]      xlen_t;
  typedef logic [RIDX_W-1:0]    ridx_t;
  typedef logic [QUBIT_NUM-1:0] qmask_t;
  typedef logic [QIDX_W-1:0]    qidx_t;
  typedef logic [TIME_W-1:0]    time_t;
  typedef logic [EVOP_W-1:0]    evop_t;
  typedef logic [CREDIT_W-1:0]  credit_t;

  //////////////////////////////////////////////////
  // enums
  //////////////////////////////////////////////////

  // decoded opcode as delivered by the instruction source
  typedef enum logic [2:0] {
    OP_ADD,
    OP_ADDI,
    OP_XOR,
    OP_FMR,
    OP_QWAIT,
    OP_QOP,
    OP_MEASURE
  } op_t;

  // dispatch buffer state
  typedef enum logic [1:0] {
    ST_EMPTY,
    ST_FULL,
    ST_STALL_MEAS,
    ST_STALL_CREDIT
  } disp_state_t;

endpackage

// File: qpu_exu_issue_if.sv
interface qpu_exu_issue_if
  import qpu_exu_pkg::*;
();

  // one-cycle strobe, instruction leaves dispatch
  logic   issue;

  // held instruction fields
  op_t    op;
  ridx_t  rd;
  xlen_t  rs1;
  xlen_t  rs2;
  xlen_t  imm;
  qmask_t qubits;

  modport disp (
    output issue, op, rd, rs1, rs2, imm, qubits
  );

  modport alu (
    input  issue, op, rd, rs1, rs2, imm, qubits
  );

  // interval only
  modport timepoint (
    input  issue, op, imm
  );

  modport track (
    input  issue, op, imm, qubits
  );

endinterface

// File: qpu_exu_wbck_if.sv
interface qpu_exu_wbck_if
  import qpu_exu_pkg::*;
();

  // classical write request
  logic   crf_wen;
  ridx_t  crf_rdidx;
  xlen_t  crf_data;

  // queue push requests
  logic   tiq_push;
  logic   evq_push;
  evop_t  evq_op;
  qmask_t evq_qubits;

  modport alu (
    output crf_wen, crf_rdidx, crf_data, tiq_push, evq_push, evq_op, evq_qubits
  );

  modport wbck (
    input  crf_wen, crf_rdidx, crf_data, tiq_push, evq_push, evq_op, evq_qubits
  );

endinterface

// File: qpu_exu_disp.sv
module qpu_exu_disp
  import qpu_exu_pkg::*;
(
  input  logic          clk,
  input  logic          i_rst_n,
  input  logic          i_valid,
  input  op_t           i_op,
  input  ridx_t         i_rd,
  input  xlen_t         i_rs1,
  input  xlen_t         i_rs2,
  input  xlen_t         i_imm,
  input  qmask_t        i_qubits,
  input  logic          i_fmr_block,
  input  logic          i_tiq_ok,
  input  logic          i_evq_ok,
  output logic          o_ready,
  qpu_exu_issue_if.disp issue_bus
);

  disp_state_t state_q;
  disp_state_t state_d;

  op_t    op_q;
  ridx_t  rd_q;
  xlen_t  rs1_q;
  xlen_t  rs2_q;
  xlen_t  imm_q;
  qmask_t qubits_q;

  logic need_meas;
  logic need_credit;
  logic credit_ok;
  logic issue;
  logic accept;

  //////////////////////////////////////////////////
  // resource check for the held op
  //////////////////////////////////////////////////

  assign need_meas   = (op_q == OP_FMR);
  assign need_credit = (op_q == OP_QWAIT) || (op_q == OP_QOP) || (op_q == OP_MEASURE);
  // qwait goes to the timing queue, the rest to the event queue
  assign credit_ok   = (op_q == OP_QWAIT) ? i_tiq_ok : i_evq_ok;

  always_comb
  begin
    case (state_q)
      ST_FULL:         issue = !(need_meas && i_fmr_block) && !(need_credit && !credit_ok);
      ST_STALL_MEAS:   issue = !i_fmr_block;
      ST_STALL_CREDIT: issue = credit_ok;
      default:         issue = 1'b0;
    endcase
  end

  // buffer frees up in the same cycle it issues
  assign o_ready = (state_q == ST_EMPTY) || issue;
  assign accept  = i_valid && o_ready;

  always_comb
  begin
    state_d = state_q;
    if (accept)
      state_d = ST_FULL;
    else if (issue)
      state_d = ST_EMPTY;
    else if (state_q == ST_FULL)
      state_d = need_meas ? ST_STALL_MEAS : ST_STALL_CREDIT;
  end

  always_ff @(posedge clk or negedge i_rst_n)
  begin
    if (!i_rst_n)
      state_q <= ST_EMPTY;
    else
      state_q <= state_d;
  end

  // instruction buffer
  always_ff @(posedge clk)
  begin
    if (accept)
    begin
      op_q     <= i_op;
      rd_q     <= i_rd;
      rs1_q    <= i_rs1;
      rs2_q    <= i_rs2;
      imm_q    <= i_imm;
      qubits_q <= i_qubits;
    end
  end

  assign issue_bus.issue  = issue;
  assign issue_bus.op     = op_q;
  assign issue_bus.rd     = rd_q;
  assign issue_bus.rs1    = rs1_q;
  assign issue_bus.rs2    = rs2_q;
  assign issue_bus.imm    = imm_q;
  assign issue_bus.qubits = qubits_q;

endmodule

// File: qpu_exu_timepoint.sv
module qpu_exu_timepoint
  import qpu_exu_pkg::*;
(
  input  logic               clk,
  input  logic               i_rst_n,
  qpu_exu_issue_if.timepoint issue_bus,
  output time_t              o_now
);

  time_t now_q;
  time_t interval;
  logic  qwait_issue;

  // interval is the low part of the immediate
  assign interval    = issue_bus.imm[TIME_W-1:0];
  assign qwait_issue = issue_bus.issue && (issue_bus.op == OP_QWAIT);

  //////////////////////////////////////////////////
  // absolute time, wraps at 2^TIME_W
  //////////////////////////////////////////////////

  always_ff @(posedge clk or negedge i_rst_n)
  begin
    if (!i_rst_n)
    begin
      now_q <= '0;
    end
    else if (qwait_issue)
    begin
      // a zero wait leaves the time unchanged
      now_q <= now_q + interval;
    end
  end

  assign o_now = now_q;

endmodule

// File: qpu_exu_meas_track.sv
module qpu_exu_meas_track
  import qpu_exu_pkg::*;
(
  input  logic           clk,
  input  logic           i_rst_n,
  input  logic           i_meas_valid,
  input  qidx_t          i_meas_qubit,
  input  logic           i_meas_result,
  qpu_exu_issue_if.track issue_bus,
  output logic           o_fmr_block,
  output logic           o_meas_bit
);

  qmask_t pending_q;
  qmask_t result_q;
  qmask_t set_mask;
  qmask_t clr_mask;
  qidx_t  fmr_qidx;

  //////////////////////////////////////////////////
  // pending mask update
  //////////////////////////////////////////////////

  assign set_mask = (issue_bus.issue && (issue_bus.op == OP_MEASURE)) ? issue_bus.qubits : '0;
  assign clr_mask = i_meas_valid ? (qmask_t'(1) << i_meas_qubit) : '0;

  always_ff @(posedge clk or negedge i_rst_n)
  begin
    if (!i_rst_n)
    begin
      pending_q <= '0;
    end
    else
    begin
      // set after clear, a new measure wins
      pending_q <= (pending_q & ~clr_mask) | set_mask;
    end
  end

  // last returned result per qubit
  always_ff @(posedge clk or negedge i_rst_n)
  begin
    if (!i_rst_n)
      result_q <= '0;
    else if (i_meas_valid)
      result_q[i_meas_qubit] <= i_meas_result;
  end

  //////////////////////////////////////////////////
  // fmr lookup for the held instruction
  //////////////////////////////////////////////////

  assign fmr_qidx    = issue_bus.imm[QIDX_W-1:0];
  assign o_fmr_block = (issue_bus.op == OP_FMR) && pending_q[fmr_qidx];
  assign o_meas_bit  = result_q[fmr_qidx];

endmodule

// File: qpu_exu_alu.sv
module qpu_exu_alu
  import qpu_exu_pkg::*;
(
  qpu_exu_issue_if.alu issue_bus,
  input  logic         i_meas_bit,
  qpu_exu_wbck_if.alu  wb_bus
);

  xlen_t result;
  logic  is_classical;
  logic  is_event;

  //////////////////////////////////////////////////
  // classical result
  //////////////////////////////////////////////////

  always_comb
  begin
    result       = '0;
    is_classical = 1'b1;
    case (issue_bus.op)
      OP_ADD:
        result = issue_bus.rs1 + issue_bus.rs2;
      OP_ADDI:
        result = issue_bus.rs1 + issue_bus.imm;
      OP_XOR:
        result = issue_bus.rs1 ^ issue_bus.rs2;
      OP_FMR:
        // measurement bit, zero extended
        result = xlen_t'(i_meas_bit);
      default:
        is_classical = 1'b0;
    endcase
  end

  assign is_event = (issue_bus.op == OP_QOP) || (issue_bus.op == OP_MEASURE);

  //////////////////////////////////////////////////
  // requests to write-back
  //////////////////////////////////////////////////

  assign wb_bus.crf_wen    = issue_bus.issue && is_classical;
  assign wb_bus.crf_rdidx  = issue_bus.rd;
  assign wb_bus.crf_data   = result;

  // qwait only pushes, the new time comes from the counter
  assign wb_bus.tiq_push   = issue_bus.issue && (issue_bus.op == OP_QWAIT);

  assign wb_bus.evq_push   = issue_bus.issue && is_event;
  assign wb_bus.evq_op     = issue_bus.imm[EVOP_W-1:0];
  assign wb_bus.evq_qubits = issue_bus.qubits;

endmodule

// File: qpu_exu_wbck.sv
module qpu_exu_wbck
  import qpu_exu_pkg::*;
#(
  parameter int TIQ_CREDITS = 4,
  parameter int EVQ_CREDITS = 4
)
(
  input  logic          clk,
  input  logic          i_rst_n,
  input  time_t         i_now,
  input  logic          i_tiq_credit,
  input  logic          i_evq_credit,
  qpu_exu_wbck_if.wbck  wb_bus,
  output logic          o_tiq_ok,
  output logic          o_evq_ok,
  output logic          o_crf_wen,
  output ridx_t         o_crf_rdidx,
  output xlen_t         o_crf_data,
  output logic          o_tiq_valid,
  output time_t         o_tiq_time,
  output logic          o_evq_valid,
  output time_t         o_evq_time,
  output evop_t         o_evq_op,
  output qmask_t        o_evq_qubits
);

  localparam credit_t TIQ_MAX = credit_t'(TIQ_CREDITS);
  localparam credit_t EVQ_MAX = credit_t'(EVQ_CREDITS);

  credit_t tiq_cnt_q;
  credit_t evq_cnt_q;

  // push and return may land on the same edge, then the count holds
  function automatic credit_t credit_next(credit_t cnt, logic push, logic ret, credit_t depth);
    credit_t nxt;
    nxt = cnt;
    if (push && !ret)
      nxt = cnt - 1'b1;
    else if (ret && !push && (cnt != depth))
      nxt = cnt + 1'b1;
    return nxt;
  endfunction

  //////////////////////////////////////////////////
  // credit counters
  //////////////////////////////////////////////////

  always_ff @(posedge clk or negedge i_rst_n)
  begin
    if (!i_rst_n)
    begin
      tiq_cnt_q <= TIQ_MAX;
      evq_cnt_q <= EVQ_MAX;
    end
    else
    begin
      tiq_cnt_q <= credit_next(tiq_cnt_q, wb_bus.tiq_push, i_tiq_credit, TIQ_MAX);
      evq_cnt_q <= credit_next(evq_cnt_q, wb_bus.evq_push, i_evq_credit, EVQ_MAX);
    end
  end

  assign o_tiq_ok = (tiq_cnt_q != '0);
  assign o_evq_ok = (evq_cnt_q != '0);

  //////////////////////////////////////////////////
  // output strobes
  //////////////////////////////////////////////////

  always_ff @(posedge clk or negedge i_rst_n)
  begin
    if (!i_rst_n)
    begin
      o_crf_wen   <= 1'b0;
      o_tiq_valid <= 1'b0;
      o_evq_valid <= 1'b0;
    end
    else
    begin
      o_crf_wen   <= wb_bus.crf_wen;
      o_tiq_valid <= wb_bus.tiq_push;
      o_evq_valid <= wb_bus.evq_push;
    end
  end

  // payloads
  always_ff @(posedge clk)
  begin
    if (wb_bus.crf_wen)
    begin
      o_crf_rdidx <= wb_bus.crf_rdidx;
      o_crf_data  <= wb_bus.crf_data;
    end
    if (wb_bus.evq_push)
    begin
      // time before any later qwait
      o_evq_time   <= i_now;
      o_evq_op     <= wb_bus.evq_op;
      o_evq_qubits <= wb_bus.evq_qubits;
    end
  end

  // counter has already stepped by the time the pulse shows
  assign o_tiq_time = i_now;

endmodule

// File: qpu_exu_top.sv
module qpu_exu_top
  import qpu_exu_pkg::*;
#(
  parameter int TIQ_CREDITS = 4,
  parameter int EVQ_CREDITS = 4
)
(
  input  logic   clk,
  input  logic   i_rst_n,

  // instruction source
  input  logic   i_valid,
  output logic   o_ready,
  input  op_t    i_op,
  input  ridx_t  i_rd,
  input  xlen_t  i_rs1,
  input  xlen_t  i_rs2,
  input  xlen_t  i_imm,
  input  qmask_t i_qubits,

  // measurement return
  input  logic   i_meas_valid,
  input  qidx_t  i_meas_qubit,
  input  logic   i_meas_result,

  // classical register write
  output logic   o_crf_wen,
  output ridx_t  o_crf_rdidx,
  output xlen_t  o_crf_data,

  // timing queue
  output logic   o_tiq_valid,
  output time_t  o_tiq_time,
  input  logic   i_tiq_credit,

  // event queue
  output logic   o_evq_valid,
  output time_t  o_evq_time,
  output evop_t  o_evq_op,
  output qmask_t o_evq_qubits,
  input  logic   i_evq_credit
);

  time_t now;
  logic  meas_bit;
  logic  fmr_block;
  logic  tiq_ok;
  logic  evq_ok;

  qpu_exu_issue_if issue_bus ();
  qpu_exu_wbck_if  wb_bus ();

  //////////////////////////////////////////////////
  // dispatch and issue side
  //////////////////////////////////////////////////

  qpu_exu_disp u_disp (
    .clk          (clk),
    .i_rst_n      (i_rst_n),
    .i_valid      (i_valid),
    .i_op         (i_op),
    .i_rd         (i_rd),
    .i_rs1        (i_rs1),
    .i_rs2        (i_rs2),
    .i_imm        (i_imm),
    .i_qubits     (i_qubits),
    .i_fmr_block  (fmr_block),
    .i_tiq_ok     (tiq_ok),
    .i_evq_ok     (evq_ok),
    .o_ready      (o_ready),
    .issue_bus    (issue_bus.disp)
  );

  qpu_exu_timepoint u_timepoint (
    .clk          (clk),
    .i_rst_n      (i_rst_n),
    .issue_bus    (issue_bus.timepoint),
    .o_now        (now)
  );

  qpu_exu_meas_track u_meas_track (
    .clk           (clk),
    .i_rst_n       (i_rst_n),
    .i_meas_valid  (i_meas_valid),
    .i_meas_qubit  (i_meas_qubit),
    .i_meas_result (i_meas_result),
    .issue_bus     (issue_bus.track),
    .o_fmr_block   (fmr_block),
    .o_meas_bit    (meas_bit)
  );

  qpu_exu_alu u_alu (
    .issue_bus    (issue_bus.alu),
    .i_meas_bit   (meas_bit),
    .wb_bus       (wb_bus.alu)
  );

  //////////////////////////////////////////////////
  // write-back and credits
  //////////////////////////////////////////////////

  qpu_exu_wbck #(
    .TIQ_CREDITS  (TIQ_CREDITS),
    .EVQ_CREDITS  (EVQ_CREDITS)
  ) u_wbck (
    .clk          (clk),
    .i_rst_n      (i_rst_n),
    .i_now        (now),
    .i_tiq_credit (i_tiq_credit),
    .i_evq_credit (i_evq_credit),
    .wb_bus       (wb_bus.wbck),
    .o_tiq_ok     (tiq_ok),
    .o_evq_ok     (evq_ok),
    .o_crf_wen    (o_crf_wen),
    .o_crf_rdidx  (o_crf_rdidx),
    .o_crf_data   (o_crf_data),
    .o_tiq_valid  (o_tiq_valid),
    .o_tiq_time   (o_tiq_time),
    .o_evq_valid  (o_evq_valid),
    .o_evq_time   (o_evq_time),
    .o_evq_op     (o_evq_op),
    .o_evq_qubits (o_evq_qubits)
  );

endmodule

// File: tb_qpu_exu.sv
module tb_qpu_exu
  import qpu_exu_pkg::*;
();

  localparam int NUM_INSTR   = 400;
  localparam int CYCLE_LIMIT = NUM_INSTR * 40;
  localparam int TIQ_DEPTH   = 4;
  localparam int EVQ_DEPTH   = 4;

  logic   clk = 1'b0;
  logic   i_rst_n;
  logic   i_valid;
  logic   o_ready;
  op_t    i_op;
  ridx_t  i_rd;
  xlen_t  i_rs1;
  xlen_t  i_rs2;
  xlen_t  i_imm;
  qmask_t i_qubits;
  logic   i_meas_valid;
  qidx_t  i_meas_qubit;
  logic   i_meas_result;
  logic   o_crf_wen;
  ridx_t  o_crf_rdidx;
  xlen_t  o_crf_data;
  logic   o_tiq_valid;
  time_t  o_tiq_time;
  logic   i_tiq_credit;
  logic   o_evq_valid;
  time_t  o_evq_time;
  evop_t  o_evq_op;
  qmask_t o_evq_qubits;
  logic   i_evq_credit;

  int     seed;
  int     mismatches;
  int     failures;
  int     cycles;
  int     n_sent;
  logic   have_instr;
  int     tiq_occ;
  int     evq_occ;

  // model state in program order
  time_t  model_time;
  qmask_t last_res;
  // busy counts from acceptance and inflight from the event pulse
  qmask_t busy;
  qmask_t inflight;

  ridx_t  exp_rd[$];
  xlen_t  exp_data[$];
  logic   exp_is_fmr[$];
  qidx_t  exp_fmr_q[$];
  time_t  exp_tiq[$];
  evop_t  exp_ev_op[$];
  qmask_t exp_ev_qubits[$];
  time_t  exp_ev_time[$];
  logic   exp_ev_meas[$];
  qmask_t exp_ev_res[$];
  qidx_t  deliver_q[$];
  logic   deliver_bit[$];

  qpu_exu_top dut0 (
    .clk           (clk),
    .i_rst_n       (i_rst_n),
    .i_valid       (i_valid),
    .o_ready       (o_ready),
    .i_op          (i_op),
    .i_rd          (i_rd),
    .i_rs1         (i_rs1),
    .i_rs2         (i_rs2),
    .i_imm         (i_imm),
    .i_qubits      (i_qubits),
    .i_meas_valid  (i_meas_valid),
    .i_meas_qubit  (i_meas_qubit),
    .i_meas_result (i_meas_result),
    .o_crf_wen     (o_crf_wen),
    .o_crf_rdidx   (o_crf_rdidx),
    .o_crf_data    (o_crf_data),
    .o_tiq_valid   (o_tiq_valid),
    .o_tiq_time    (o_tiq_time),
    .i_tiq_credit  (i_tiq_credit),
    .o_evq_valid   (o_evq_valid),
    .o_evq_time    (o_evq_time),
    .o_evq_op      (o_evq_op),
    .o_evq_qubits  (o_evq_qubits),
    .i_evq_credit  (i_evq_credit)
  );

  always #2 clk = ~clk;

  function automatic logic [31:0] rand_word();
    return $random(seed);
  endfunction

  function automatic int rand_below(input int n);
    logic [31:0] w;
    w = $random(seed);
    return int'(w % n);
  endfunction

  function automatic logic all_done();
    return (n_sent == NUM_INSTR) && (exp_rd.size() == 0) && (exp_tiq.size() == 0)
      && (exp_ev_op.size() == 0) && (deliver_q.size() == 0);
  endfunction

  //////////////////////////////////////////////////
  // stimulus and reference model
  //////////////////////////////////////////////////

  task automatic pick_instr();
    logic [31:0] w;
    w        = rand_word();
    i_rd     = w[RIDX_W-1:0];
    i_qubits = w[15:8];
    i_rs1    = rand_word();
    i_rs2    = rand_word();
    i_imm    = rand_word();
    case (rand_below(7))
      0:       i_op = OP_ADD;
      1:       i_op = OP_ADDI;
      2:       i_op = OP_XOR;
      3:       i_op = OP_FMR;
      4:       i_op = OP_QWAIT;
      5:       i_op = OP_QOP;
      default: i_op = OP_MEASURE;
    endcase
    // only one measurement per qubit out at a time
    if (i_op == OP_MEASURE)
    begin
      i_qubits = i_qubits & ~busy;
      if (i_qubits == '0)
        i_op = OP_QOP;
    end
  endtask

  task automatic push_write(input ridx_t rd, input xlen_t data, input logic is_fmr,
                            input qidx_t q);
    exp_rd.push_back(rd);
    exp_data.push_back(data);
    exp_is_fmr.push_back(is_fmr);
    exp_fmr_q.push_back(q);
  endtask

  task automatic accept_instr();
    qidx_t       q;
    qmask_t      res;
    logic [31:0] w;
    q = i_imm[QIDX_W-1:0];
    case (i_op)
      OP_ADD:   push_write(i_rd, i_rs1 + i_rs2, 1'b0, q);
      OP_ADDI:  push_write(i_rd, i_rs1 + i_imm, 1'b0, q);
      OP_XOR:   push_write(i_rd, i_rs1 ^ i_rs2, 1'b0, q);
      OP_FMR:   push_write(i_rd, {{(XLEN-1){1'b0}}, last_res[q]}, 1'b1, q);
      OP_QWAIT:
      begin
        model_time = model_time + i_imm[TIME_W-1:0];
        exp_tiq.push_back(model_time);
      end
      default:
      begin
        res = '0;
        if (i_op == OP_MEASURE)
        begin
          // results are fixed now and returned after the event shows up
          w        = rand_word();
          res      = w[QUBIT_NUM-1:0];
          last_res = (last_res & ~i_qubits) | (res & i_qubits);
          busy     = busy | i_qubits;
        end
        exp_ev_op.push_back(i_imm[EVOP_W-1:0]);
        exp_ev_qubits.push_back(i_qubits);
        exp_ev_time.push_back(model_time);
        exp_ev_meas.push_back(i_op == OP_MEASURE);
        exp_ev_res.push_back(res);
      end
    endcase
  endtask

  task automatic drive_inputs();
    i_tiq_credit = 1'b0;
    if (tiq_occ > 0 && rand_below(3) == 0)
    begin
      i_tiq_credit = 1'b1;
      tiq_occ--;
    end
    i_evq_credit = 1'b0;
    if (evq_occ > 0 && rand_below(3) == 0)
    begin
      i_evq_credit = 1'b1;
      evq_occ--;
    end
    i_meas_valid = 1'b0;
    if (deliver_q.size() > 0 && rand_below(3) == 0)
    begin
      i_meas_valid  = 1'b1;
      i_meas_qubit  = deliver_q.pop_front();
      i_meas_result = deliver_bit.pop_front();
    end
    // held stable until the handshake
    if (!have_instr)
    begin
      i_valid = 1'b0;
      if (n_sent < NUM_INSTR && rand_below(4) != 0)
      begin
        pick_instr();
        i_valid    = 1'b1;
        have_instr = 1'b1;
      end
    end
  endtask

  //////////////////////////////////////////////////
  // output checks at mid-cycle
  //////////////////////////////////////////////////

  task automatic check_outputs();
    ridx_t  rd;
    xlen_t  data;
    logic   is_fmr;
    qidx_t  q;
    time_t  t;
    evop_t  op;
    qmask_t qb;
    logic   meas;
    qmask_t res;
    int     k;
    if (o_crf_wen)
    begin
      if (exp_rd.size() == 0)
      begin
        $display("ERROR @%0t: classical write that no instruction asked for", $time);
        failures++;
      end
      else
      begin
        rd     = exp_rd.pop_front();
        data   = exp_data.pop_front();
        is_fmr = exp_is_fmr.pop_front();
        q      = exp_fmr_q.pop_front();
        if (o_crf_rdidx !== rd || o_crf_data !== data)
        begin
          $display("MISMATCH @%0t: crf rd=%0d data=%h, expected rd=%0d data=%h",
                   $time, o_crf_rdidx, o_crf_data, rd, data);
          mismatches++;
        end
        if (is_fmr && inflight[q])
        begin
          $display("ERROR @%0t: FMR of qubit %0d written before its result came back",
                   $time, q);
          failures++;
        end
      end
    end
    if (o_tiq_valid)
    begin
      tiq_occ++;
      if (tiq_occ > TIQ_DEPTH)
      begin
        $display("ERROR @%0t: timing queue credit overflow, %0d entries held", $time, tiq_occ);
        failures++;
      end
      if (exp_tiq.size() == 0)
      begin
        $display("ERROR @%0t: timing queue push that no QWAIT asked for", $time);
        failures++;
      end
      else
      begin
        t = exp_tiq.pop_front();
        if (o_tiq_time !== t)
        begin
          $display("MISMATCH @%0t: tiq time=%0d, expected %0d", $time, o_tiq_time, t);
          mismatches++;
        end
      end
    end
    if (o_evq_valid)
    begin
      evq_occ++;
      if (evq_occ > EVQ_DEPTH)
      begin
        $display("ERROR @%0t: event queue credit overflow, %0d entries held", $time, evq_occ);
        failures++;
      end
      if (exp_ev_op.size() == 0)
      begin
        $display("ERROR @%0t: event push that no instruction asked for", $time);
        failures++;
      end
      else
      begin
        op   = exp_ev_op.pop_front();
        qb   = exp_ev_qubits.pop_front();
        t    = exp_ev_time.pop_front();
        meas = exp_ev_meas.pop_front();
        res  = exp_ev_res.pop_front();
        if (o_evq_op !== op || o_evq_qubits !== qb || o_evq_time !== t)
        begin
          $display("MISMATCH @%0t: evq op=%h qubits=%b time=%0d, expected op=%h qubits=%b time=%0d",
                   $time, o_evq_op, o_evq_qubits, o_evq_time, op, qb, t);
          mismatches++;
        end
        if (meas)
        begin
          inflight = inflight | qb;
          for (k = 0; k < QUBIT_NUM; k++)
          begin
            if (qb[k])
            begin
              deliver_q.push_back(qidx_t'(k));
              deliver_bit.push_back(res[k]);
            end
          end
        end
      end
    end
    // dut takes the result at the next edge
    if (i_meas_valid)
    begin
      busy[i_meas_qubit]     = 1'b0;
      inflight[i_meas_qubit] = 1'b0;
    end
    if (i_valid && o_ready)
    begin
      accept_instr();
      n_sent++;
      have_instr = 1'b0;
    end
  endtask

  initial
  begin
    seed          = 32'hc972_927a;
    mismatches    = 0;
    failures      = 0;
    cycles        = 0;
    n_sent        = 0;
    have_instr    = 1'b0;
    tiq_occ       = 0;
    evq_occ       = 0;
    model_time    = '0;
    last_res      = '0;
    busy          = '0;
    inflight      = '0;
    i_rst_n       = 1'b0;
    i_valid       = 1'b0;
    i_op          = OP_ADD;
    i_rd          = '0;
    i_rs1         = '0;
    i_rs2         = '0;
    i_imm         = '0;
    i_qubits      = '0;
    i_meas_valid  = 1'b0;
    i_meas_qubit  = '0;
    i_meas_result = 1'b0;
    i_tiq_credit  = 1'b0;
    i_evq_credit  = 1'b0;

    repeat (10) @(posedge clk);
    #1 i_rst_n = 1'b1;
    @(negedge clk);
    if (o_ready !== 1'b1 || o_crf_wen !== 1'b0 || o_tiq_valid !== 1'b0 || o_evq_valid !== 1'b0)
    begin
      $display("ERROR @%0t: DUT not idle and ready after reset", $time);
      failures++;
    end

    while (!all_done() && cycles < CYCLE_LIMIT)
    begin
      @(posedge clk);
      #1;
      drive_inputs();
      @(negedge clk);
      check_outputs();
      cycles++;
    end

    if (!all_done())
    begin
      $display("ERROR: timeout after %0d cycles, %0d of %0d instructions accepted", cycles,
               n_sent, NUM_INSTR);
      $display("ERROR: still expected %0d writes, %0d timing and %0d event entries",
               exp_rd.size(), exp_tiq.size(), exp_ev_op.size());
      failures++;
    end

    $display("%0d mismatches, %0d other errors", mismatches, failures);
    if (mismatches == 0 && failures == 0)
      $display("*** PASSED ***");
    else
      $display("*** FAILED ***");
    $finish;
  end

endmodule

// File: qpu_exu.f
qpu_exu_pkg.sv
qpu_exu_issue_if.sv
qpu_exu_wbck_if.sv
qpu_exu_disp.sv
qpu_exu_timepoint.sv
qpu_exu_meas_track.sv
qpu_exu_alu.sv
qpu_exu_wbck.sv
qpu_exu_top.sv
tb_qpu_exu.sv

// File: run_sim.sh
#!/bin/sh
# build and run the testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --top-module tb_qpu_exu -f qpu_exu.f -o sim_qpu_exu

./obj_dir/sim_qpu_exu > sim.log 2>&1
cat sim.log

if grep -qF '*** FAILED ***' sim.log; then
  exit 1
fi
grep -qF '*** PASSED ***' sim.log
